// File: vlog.f
+incdir+hw
hw/csr_pkg.sv
hw/csr_req_if.sv
hw/csr_rsp_if.sv
hw/csr_decoder.sv
hw/csr_file.sv
hw/csr_response.sv
hw/csr_unit_top.sv
sim/csr_unit_props.sv
sim/csr_unit_tb.sv

// File: sim/csr_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "csr_config.svh"

module csr_unit_tb;
    import csr_pkg::*;

    localparam int NUM_REQ        = 400;
    localparam int TIMEOUT_CYCLES = NUM_REQ + 50;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    instr_t     instruction;
    csr_data_t  operand;
    csr_funct_e operation;
    priv_lvl_e  privilege;
    logic       rsp_valid;
    reg_idx_t   rsp_rd;
    csr_data_t  rsp_rdata;
    logic       rsp_rd_write;
    logic       rsp_exception;

    // Writable CSR values: uscratch, sscratch, sepc, mscratch, mepc.
    csr_data_t   model [5];
    csr_addr_t   impl_addrs [7] = '{`CSR_ADDR_USCRATCH, `CSR_ADDR_SSCRATCH, `CSR_ADDR_SEPC,
                                    `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC,
                                    `CSR_ADDR_MVENDORID, `CSR_ADDR_MHARTID};
    csr_addr_t   last_addr;
    logic [39:0] exp_q [$];
    string       name_q [$];
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int unsigned seed_val;

    csr_unit_top u_dut (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .req_valid_i     (req_valid),
        .instruction_i   (instruction),
        .operand_i       (operand),
        .operation_i     (operation),
        .privilege_i     (privilege),
        .rsp_valid_o     (rsp_valid),
        .rsp_rd_o        (rsp_rd),
        .rsp_rdata_o     (rsp_rdata),
        .rsp_rd_write_o  (rsp_rd_write),
        .rsp_exception_o (rsp_exception)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles (checks %0d, errors %0d)",
                     TIMEOUT_CYCLES, check_count, error_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model.
    ////////////////////////////////////////////////////////////
    function automatic int csr_slot(input csr_addr_t addr);
        case (addr)
            `CSR_ADDR_USCRATCH: return 0;
            `CSR_ADDR_SSCRATCH: return 1;
            `CSR_ADDR_SEPC:     return 2;
            `CSR_ADDR_MSCRATCH: return 3;
            `CSR_ADDR_MEPC:     return 4;
            default:            return -1;
        endcase
    endfunction

    function automatic logic csr_known(input csr_addr_t addr);
        return (csr_slot(addr) >= 0) || (addr == `CSR_ADDR_MVENDORID) ||
               (addr == `CSR_ADDR_MHARTID);
    endfunction

    function automatic csr_data_t model_read(input csr_addr_t addr);
        int slot;
        slot = csr_slot(addr);
        if (slot >= 0) begin
            return model[slot];
        end
        return (addr == `CSR_ADDR_MHARTID) ? `CSR_HART_ID : '0;
    endfunction

    task automatic drive_request(input int idx);
        csr_addr_t  addr;
        reg_idx_t   rd_f;
        reg_idx_t   rs1_f;
        csr_data_t  opnd_val;
        csr_data_t  wval;
        csr_data_t  old_val;
        csr_data_t  new_val;
        csr_funct_e funct;
        priv_lvl_e  priv;
        logic       valid;
        logic       rd_en;
        logic       wr_en;
        logic       exc;
        logic       rd_wr;
        valid    = ($urandom_range(7, 0) != 0);
        funct    = csr_funct_e'($urandom_range(6, 0));
        rd_f     = ($urandom_range(3, 0) == 0) ? 5'd0 : 5'($urandom_range(31, 1));
        rs1_f    = ($urandom_range(3, 0) == 0) ? 5'd0 : 5'($urandom_range(31, 1));
        opnd_val = $urandom;
        case ($urandom_range(3, 0))
            0:       priv = PRIV_U;
            1:       priv = PRIV_S;
            default: priv = PRIV_M;
        endcase
        // Reuse the last address now and then for back-to-back traffic.
        if (idx > 0 && $urandom_range(3, 0) == 0) begin
            addr = last_addr;
        end else if ($urandom_range(9, 0) < 8) begin
            addr = impl_addrs[$urandom_range(6, 0)];
        end else begin
            addr = 12'($urandom);
        end
        last_addr = addr;

        rd_en = 1'b0;
        wr_en = 1'b0;
        case (funct)
            CSRRW, CSRRWI: begin
                rd_en = (rd_f != 5'd0);
                wr_en = 1'b1;
            end
            CSRRS, CSRRSI, CSRRC, CSRRCI: begin
                rd_en = 1'b1;
                wr_en = (rs1_f != 5'd0);
            end
            default: rd_en = 1'b0;
        endcase
        wval = (funct inside {CSRRWI, CSRRSI, CSRRCI}) ? {27'd0, rs1_f} : opnd_val;
        exc  = (wr_en && addr[11:10] == 2'b11) ||
               ((rd_en || wr_en) && (addr[9:8] > priv)) ||
               ((rd_en || wr_en) && !csr_known(addr));

        old_val = model_read(addr);
        case (funct)
            CSRRW, CSRRWI: new_val = wval;
            CSRRS, CSRRSI: new_val = old_val | wval;
            CSRRC, CSRRCI: new_val = old_val & ~wval;
            default:       new_val = old_val;
        endcase
        if (valid && wr_en && !exc && csr_slot(addr) >= 0) begin
            if (addr == `CSR_ADDR_SEPC || addr == `CSR_ADDR_MEPC) begin
                new_val[1:0] = 2'b00;
            end
            model[csr_slot(addr)] = new_val;
        end
        rd_wr = valid && rd_en && !exc;
        exp_q.push_back({valid, rd_wr, valid && exc, rd_f, rd_wr ? old_val : 32'h0});
        name_q.push_back($sformatf("req %0d %s @%03h %s", idx, funct.name(), addr, priv.name()));

        req_valid   <= valid;
        instruction <= {addr, rs1_f, 3'b001, rd_f, 7'h73};
        operand     <= opnd_val;
        operation   <= funct;
        privilege   <= priv;
    endtask

    ////////////////////////////////////////////////////////////
    // Checking.
    ////////////////////////////////////////////////////////////
    task automatic check_field(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        check_count++;
        assert (act_val === exp_val) else begin
            error_count++;
            $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, exp_val, act_val);
        end
    endtask

    task automatic check_response();
        logic [39:0] e;
        string       nm;
        e  = exp_q.pop_front();
        nm = name_q.pop_front();
        check_field({nm, " valid"}, 32'(e[39]), 32'(rsp_valid));
        check_field({nm, " rd_write"}, 32'(e[38]), 32'(rsp_rd_write));
        check_field({nm, " exception"}, 32'(e[37]), 32'(rsp_exception));
        check_field({nm, " rdata"}, e[31:0], rsp_rdata);
        if (e[39]) begin
            check_field({nm, " rd"}, 32'(e[36:32]), 32'(rsp_rd));
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        instruction = '0;
        operand     = '0;
        operation   = CSR_NONE;
        privilege   = PRIV_M;
        last_addr   = '0;
        foreach (model[k]) begin
            model[k] = '0;
        end
        seed_val = $urandom(57);

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Response to a request is checked at the falling edge one cycle later.
        for (int i = 0; i < NUM_REQ; i++) begin
            @(posedge clk);
            drive_request(i);
            @(negedge clk);
            if (i > 0) begin
                check_response();
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;
        @(negedge clk);
        check_response();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/csr_unit_props.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit_props (
    input logic clk_i,
    input logic rst_n_i,
    input logic req_valid_i,
    input logic rsp_valid_o,
    input logic rsp_rd_write_o,
    input logic rsp_exception_o
);

    // Response valid trails the sampled request by one cycle.
    valid_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(rst_n_i) |-> (rsp_valid_o == $past(req_valid_i)))
        else $error("rsp_valid_o did not follow req_valid_i by one cycle");

    // A faulting access never writes rd.
    no_write_on_exception: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(rsp_rd_write_o && rsp_exception_o))
        else $error("rsp_rd_write_o and rsp_exception_o high together");

    // Reset clears the response flags.
    flags_clear_after_reset: assert property (@(posedge clk_i)
        !$past(rst_n_i) |-> (!rsp_valid_o && !rsp_rd_write_o && !rsp_exception_o))
        else $error("response flags not cleared by reset");

endmodule

bind csr_unit_top csr_unit_props u_props (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_valid_i     (req_valid_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_rd_write_o  (rsp_rd_write_o),
    .rsp_exception_o (rsp_exception_o)
);

`default_nettype wire

// File: hw/csr_unit_top.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    // Request from the core.
    input  logic                req_valid_i,
    input  csr_pkg::instr_t     instruction_i,
    input  csr_pkg::csr_data_t  operand_i,
    input  csr_pkg::csr_funct_e operation_i,
    input  csr_pkg::priv_lvl_e  privilege_i,
    // Writeback response.
    output logic                rsp_valid_o,
    output csr_pkg::reg_idx_t   rsp_rd_o,
    output csr_pkg::csr_data_t  rsp_rdata_o,
    output logic                rsp_rd_write_o,
    output logic                rsp_exception_o
);

    csr_req_if req_if ();
    csr_rsp_if rsp_if ();

    ////////////////////////////////////////////////////////////
    // Decode, bank, response.
    ////////////////////////////////////////////////////////////
    csr_decoder u_decoder (
        .req_valid_i   (req_valid_i),
        .instruction_i (instruction_i),
        .operand_i     (operand_i),
        .operation_i   (operation_i),
        .privilege_i   (privilege_i),
        .req           (req_if.dec)
    );

    csr_file u_file (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req     (req_if.bank),
        .rsp     (rsp_if.bank)
    );

    csr_response u_response (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .rsp             (rsp_if.resp),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_rd_o        (rsp_rd_o),
        .rsp_rdata_o     (rsp_rdata_o),
        .rsp_rd_write_o  (rsp_rd_write_o),
        .rsp_exception_o (rsp_exception_o)
    );

endmodule

`default_nettype wire

// File: hw/csr_response.sv
`timescale 1ns/10ps
`default_nettype none

module csr_response (
    input  logic               clk_i,
    input  logic               rst_n_i,
    csr_rsp_if.resp            rsp,
    output logic               rsp_valid_o,
    output csr_pkg::reg_idx_t  rsp_rd_o,
    output csr_pkg::csr_data_t rsp_rdata_o,
    output logic               rsp_rd_write_o,
    output logic               rsp_exception_o
);
    import csr_pkg::*;

    reg_idx_t  rd_q;
    csr_data_t rdata_q;

    // Control flags, cleared on reset.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_o     <= 1'b0;
            rsp_rd_write_o  <= 1'b0;
            rsp_exception_o <= 1'b0;
        end else begin
            rsp_valid_o     <= rsp.valid;
            rsp_rd_write_o  <= rsp.rd_write;
            rsp_exception_o <= rsp.exception;
        end
    end

    // Payload.
    always_ff @(posedge clk_i) begin
        rd_q    <= rsp.rd;
        // No stale data when rd is not written.
        rdata_q <= rsp.rd_write ? rsp.rdata : '0;
    end

    assign rsp_rd_o    = rd_q;
    assign rsp_rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: hw/csr_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "csr_config.svh"

module csr_file (
    input  logic    clk_i,
    input  logic    rst_n_i,
    csr_req_if.bank req,
    csr_rsp_if.bank rsp
);
    import csr_pkg::*;

    // Writable CSRs.
    csr_data_t uscratch_q;
    csr_data_t sscratch_q;
    csr_data_t sepc_q;
    csr_data_t mscratch_q;
    csr_data_t mepc_q;

    csr_data_t old_value;
    csr_data_t new_value;
    logic      implemented;
    logic      access;
    logic      exc;
    logic      wr_allow;

    ////////////////////////////////////////////////////////////
    // Read port and address decode.
    ////////////////////////////////////////////////////////////
    always_comb begin
        old_value   = '0;
        implemented = 1'b1;
        case (req.addr)
            `CSR_ADDR_USCRATCH:  old_value = uscratch_q;
            `CSR_ADDR_SSCRATCH:  old_value = sscratch_q;
            `CSR_ADDR_SEPC:      old_value = sepc_q;
            `CSR_ADDR_MSCRATCH:  old_value = mscratch_q;
            `CSR_ADDR_MEPC:      old_value = mepc_q;
            // Vendor id not implemented, reads zero.
            `CSR_ADDR_MVENDORID: old_value = '0;
            `CSR_ADDR_MHARTID:   old_value = csr_data_t'(`CSR_HART_ID);
            default: begin
                implemented = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Read-modify-write.
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (req.op)
            OP_WRITE: new_value = req.wdata;
            OP_SET:   new_value = old_value | req.wdata;
            OP_CLEAR: new_value = old_value & ~req.wdata;
            default:  new_value = old_value;
        endcase
    end

    assign access   = req.rd_en || req.wr_en;
    // Unimplemented address only faults on a real access.
    assign exc      = req.perm_exc || (access && !implemented);
    assign wr_allow = req.valid && req.wr_en && !exc;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            uscratch_q <= '0;
            sscratch_q <= '0;
            sepc_q     <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
        end else if (wr_allow) begin
            case (req.addr)
                `CSR_ADDR_USCRATCH: uscratch_q <= new_value;
                `CSR_ADDR_SSCRATCH: sscratch_q <= new_value;
                // EPC low bits are hardwired to zero.
                `CSR_ADDR_SEPC:     sepc_q     <= {new_value[`CSR_XLEN-1:2], 2'b00};
                `CSR_ADDR_MSCRATCH: mscratch_q <= new_value;
                `CSR_ADDR_MEPC:     mepc_q     <= {new_value[`CSR_XLEN-1:2], 2'b00};
                default: begin
                    // Read-only entries never reach here.
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Result towards the response stage.
    ////////////////////////////////////////////////////////////
    assign rsp.valid     = req.valid;
    assign rsp.rdata     = old_value;
    assign rsp.rd        = req.rd;
    assign rsp.exception = req.valid && exc;
    assign rsp.rd_write  = req.valid && req.rd_en && !exc;

endmodule

`default_nettype wire

// File: hw/csr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module csr_decoder (
    input  logic                req_valid_i,
    input  csr_pkg::instr_t     instruction_i,
    input  csr_pkg::csr_data_t  operand_i,
    input  csr_pkg::csr_funct_e operation_i,
    input  csr_pkg::priv_lvl_e  privilege_i,
    csr_req_if.dec              req
);
    import csr_pkg::*;

    reg_idx_t  rd_idx;
    reg_idx_t  rs1_idx;
    csr_addr_t csr_addr;
    csr_op_e   op;
    logic      rd_en;
    logic      wr_en;
    logic      imm_form;
    logic      ro_violation;
    logic      priv_violation;

    ////////////////////////////////////////////////////////////
    // Instruction fields.
    ////////////////////////////////////////////////////////////
    assign rd_idx   = instruction_i[11:7];
    assign rs1_idx  = instruction_i[19:15];
    assign csr_addr = instruction_i[31:20];

    ////////////////////////////////////////////////////////////
    // Operation and access intent.
    ////////////////////////////////////////////////////////////
    always_comb begin
        op    = OP_NONE;
        rd_en = 1'b0;
        wr_en = 1'b0;
        case (operation_i)
            CSRRW, CSRRWI: begin
                // Swap always writes; x0 destination skips the read.
                op    = OP_WRITE;
                wr_en = 1'b1;
                rd_en = (rd_idx != '0);
            end
            CSRRS, CSRRSI: begin
                op    = OP_SET;
                rd_en = 1'b1;
                wr_en = (rs1_idx != '0);
            end
            CSRRC, CSRRCI: begin
                op    = OP_CLEAR;
                rd_en = 1'b1;
                wr_en = (rs1_idx != '0);
            end
            default: begin
                op = OP_NONE;
            end
        endcase
    end

    // Immediate forms take the rs1 field, zero-extended.
    assign imm_form = (operation_i == CSRRWI) ||
                      (operation_i == CSRRSI) ||
                      (operation_i == CSRRCI);

    ////////////////////////////////////////////////////////////
    // Permission checks.
    ////////////////////////////////////////////////////////////

    // Top quarter of the space is read-only.
    assign ro_violation   = wr_en && (csr_addr[11:10] == 2'b11);
    // Minimum privilege is encoded in addr[9:8].
    assign priv_violation = (rd_en || wr_en) && (csr_addr[9:8] > privilege_i);

    assign req.valid    = req_valid_i;
    assign req.rd_en    = rd_en;
    assign req.wr_en    = wr_en;
    assign req.op       = op;
    assign req.addr     = csr_addr;
    assign req.wdata    = imm_form ? csr_data_t'(rs1_idx) : operand_i;
    assign req.rd       = rd_idx;
    assign req.perm_exc = ro_violation || priv_violation;

endmodule

`default_nettype wire

// File: hw/csr_rsp_if.sv
`timescale 1ns/10ps
`default_nettype none

interface csr_rsp_if;
    import csr_pkg::*;

    logic      valid;
    logic      rd_write;
    logic      exception;
    reg_idx_t  rd;
    csr_data_t rdata;

    modport bank (
        output valid, rdata, rd, rd_write, exception
    );

    modport resp (
        input valid, rdata, rd, rd_write, exception
    );

endinterface

`default_nettype wire

// File: hw/csr_req_if.sv
`timescale 1ns/10ps
`default_nettype none

interface csr_req_if;
    import csr_pkg::*;

    logic      valid;
    logic      rd_en;
    logic      wr_en;
    csr_op_e   op;
    csr_addr_t addr;
    csr_data_t wdata;
    reg_idx_t  rd;
    // Read-only or privilege violation.
    logic      perm_exc;

    modport dec (
        output valid, rd_en, wr_en, op, addr, wdata, rd, perm_exc
    );

    modport bank (
        input valid, rd_en, wr_en, op, addr, wdata, rd, perm_exc
    );

endinterface

`default_nettype wire

// File: hw/csr_pkg.sv
`default_nettype none

`include "csr_config.svh"

package csr_pkg;

    ////////////////////////////////////////////////////////////
    // Vector types.
    ////////////////////////////////////////////////////////////

    // CSR data word.
    typedef logic [`CSR_XLEN-1:0] csr_data_t;
    // CSR address space is 4K entries.
    typedef logic [11:0] csr_addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] instr_t;

    ////////////////////////////////////////////////////////////
    // Enumerations.
    ////////////////////////////////////////////////////////////

    // Instruction requested by the core.
    typedef enum logic [2:0] {
        CSR_NONE,
        CSRRW,
        CSRRS,
        CSRRC,
        CSRRWI,
        CSRRSI,
        CSRRCI
    } csr_funct_e;

    // Operation applied to the CSR bank.
    typedef enum logic [1:0] {
        OP_NONE,
        OP_WRITE,
        OP_SET,
        OP_CLEAR
    } csr_op_e;

    // Encoding matches addr[9:8] of the CSR space.
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_lvl_e;

endpackage

`default_nettype wire

// File: hw/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Data path width.
`define CSR_XLEN 32

////////////////////////////////////////////////////////////
// Implemented CSR addresses.
////////////////////////////////////////////////////////////
`define CSR_ADDR_USCRATCH  12'h040
`define CSR_ADDR_SSCRATCH  12'h140
`define CSR_ADDR_SEPC      12'h141
`define CSR_ADDR_MSCRATCH  12'h340
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MVENDORID 12'hF11
`define CSR_ADDR_MHARTID   12'hF14

// Value returned by mhartid.
`define CSR_HART_ID 32'h0000_0003

`endif
